/* dv/controlGolden.txt */
// columns: opcode funct aluZero cycles execState aluOp pcLoad regWriteState
// all hex, states in ctrlStateT encoding, regWriteState 00 means no register write
// number of records
12
// R-type, write back through the R write state
00 20 0 06 05 1 0 09  // add
00 24 0 06 06 3 0 09  // and
00 22 1 06 07 2 0 09  // sub
00 26 0 06 08 6 0 09  // xor
00 00 0 05 0a 0 0 00  // nop
// branches, both zero flag values
04 00 1 05 0c 2 1 00  // beq taken
04 00 0 05 0c 2 0 00  // beq not taken
05 00 1 05 0d 2 0 00  // bne not taken
05 00 0 05 0d 2 1 00  // bne taken
// memory access
23 00 0 09 10 1 0 14  // lw, ends in write-back
2b 00 0 07 15 1 0 00  // sw
// upper immediate and jump
0f 00 0 05 0f 0 0 0f  // lui
02 00 0 05 0e 1 1 00  // j
// unknown codes idle one cycle in nop
3f 00 0 05 0a 0 0 00  // illegal opcode
00 3f 0 05 0a 0 0 00  // illegal funct
23 00 1 09 10 1 0 14  // lw, zero flag ignored
// break parks the FSM, cycles is the observation length
00 0d 0 08 0b 0 0 00  // break
00 20 1 06 05 1 0 09  // add after reset

/* vlog.f */
design/mipsCtrlPkg.sv
design/instrDecode.sv
design/stateSequencer.sv
design/controlWordGen.sv
design/mipsControl.sv
dv/mipsControl_properties.sv
dv/tbMipsControl.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and decide from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tbMipsControl \
	-f vlog.f -o simMipsControl > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/simMipsControl > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation ended without a result, see sim.log"; exit 1; }
echo "simulation passed"
exit 0

/* dv/tbMipsControl.sv */
`timescale 1ns/1ps
`default_nettype none

module tbMipsControl;

	import mipsCtrlPkg::*;

	localparam int Period = 100;
	localparam int ResetCycles = 16;
	localparam int RecordWords = 8;
	localparam int MaxRecords = 32;
	localparam int MaxSteps = 16;	// runaway guard per instruction

	logic Clk = 1'b0;
	logic rst;
	opcodeT op;
	functT funct;
	logic aluZero;
	ctrlStateT ctrlState;
	ctrlOutT ctrl;

	logic [7:0] goldenMem [0:MaxRecords*RecordWords];	// word 0 is the record count
	int recordCount = 0;
	int watchCycles = 0;
	logic fileLoaded = 1'b0;
	int checkCount = 0;
	int errorCount = 0;

	mipsControl i_mipsControl
	(
		.Clk (Clk),
		.rst (rst),
		.op (op),
		.funct (funct),
		.aluZero (aluZero),
		.ctrlState (ctrlState),
		.ctrl (ctrl)
	);

	always #(Period/2) Clk = ~Clk;

	task automatic compareState(input ctrlStateT got, input ctrlStateT exp, input string what);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("ERROR at time %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic compareAluOp(input aluOpT got, input aluOpT exp, input string what);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("ERROR at time %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic compareSrcA(input aluSrcAT got, input aluSrcAT exp, input string what);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("ERROR at time %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic compareSrcB(input aluSrcBT got, input aluSrcBT exp, input string what);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("ERROR at time %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic compareWbSel(input memToRegT got, input memToRegT exp, input string what);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("ERROR at time %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic comparePcSrc(input pcSourceT got, input pcSourceT exp, input string what);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("ERROR at time %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic compareBit(input logic got, input logic exp, input string what);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("ERROR at time %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compareCount(input int got, input int exp, input string what);
		checkCount++;
		if (got != exp)
		begin
			errorCount++;
			$display("ERROR at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic loadGolden;
		int total;
		int breakCount;
		total = 0;
		breakCount = 0;
		$readmemh("dv/controlGolden.txt", goldenMem);
		recordCount = int'(goldenMem[0]);
		for (int r = 0; r < recordCount && r < MaxRecords; r++)
		begin
			total += int'(goldenMem[1 + r*RecordWords + 3]);
			if (ctrlStateT'(goldenMem[1 + r*RecordWords + 4]) == CtrlBreak)
				breakCount++;	// each break costs one more reset
		end
		watchCycles = total + (ResetCycles + 2) * (1 + breakCount);
		fileLoaded = 1'b1;
	endtask

	task automatic checkResetWord;
		compareBit(ctrl.word.regReset, 1'b1, "regReset in reset");
		compareBit(ctrl.word.aReset, 1'b1, "aReset in reset");
		compareBit(ctrl.word.bReset, 1'b1, "bReset in reset");
		compareBit(ctrl.word.mdrReset, 1'b1, "mdrReset in reset");
		compareBit(ctrl.word.aluOutReset, 1'b1, "aluOutReset in reset");
		compareBit(ctrl.word.irReset, 1'b1, "irReset in reset");
		compareBit(ctrl.word.memWrite, 1'b0, "memWrite in reset");
		compareBit(ctrl.word.irWrite, 1'b0, "irWrite in reset");
		compareBit(ctrl.word.mdrLoad, 1'b0, "mdrLoad in reset");
		compareBit(ctrl.word.regWrite, 1'b0, "regWrite in reset");
		compareBit(ctrl.word.pcWrite, 1'b0, "pcWrite in reset");
		compareBit(ctrl.word.pcWriteCond, 1'b0, "pcWriteCond in reset");
		compareBit(ctrl.word.aLoad, 1'b0, "aLoad in reset");
		compareBit(ctrl.word.bLoad, 1'b0, "bLoad in reset");
		compareBit(ctrl.word.aluOutLoad, 1'b0, "aluOutLoad in reset");
		compareBit(ctrl.pcLoad, 1'b0, "pcLoad in reset");
	endtask

	// entered and left at a falling edge
	task automatic applyReset;
		@(posedge Clk);
		#1;
		rst = 1'b1;
		for (int i = 0; i < ResetCycles; i++)
		begin
			@(negedge Clk);
			if (i > 0)
				checkResetWord();	// first sample still shows the old state
			@(posedge Clk);
			#1;
		end
		rst = 1'b0;
		@(negedge Clk);
		compareState(ctrlState, CtrlReset, "state right after reset release");
		checkResetWord();
		@(negedge Clk);
		compareState(ctrlState, CtrlFetch, "state two cycles after reset release");
	endtask

	task automatic checkCycleRules;
		logic expPcLoad;
		expPcLoad = (ctrlState == CtrlFetchWait2) || (ctrlState == CtrlJump)
			|| (ctrlState == CtrlBeq && aluZero) || (ctrlState == CtrlBne && !aluZero);
		compareBit(ctrl.pcLoad, expPcLoad, "pcLoad");
		case (ctrlState)
			CtrlFetchWait1, CtrlFetchWait2:
			begin
				compareBit(ctrl.word.irWrite, 1'b1, "irWrite in fetch");
				compareBit(ctrl.word.mdrLoad, 1'b1, "mdrLoad in fetch");
				compareSrcB(ctrl.word.aluSrcB, SrcBFour, "fetch ALU source B");
			end
			CtrlDecode:
			begin
				compareBit(ctrl.word.aLoad, 1'b1, "aLoad in decode");
				compareBit(ctrl.word.bLoad, 1'b1, "bLoad in decode");
				compareBit(ctrl.word.aluOutLoad, 1'b1, "ALUOut load in decode");
				compareSrcA(ctrl.word.aluSrcA, SrcAPc, "decode ALU source A");
				compareSrcB(ctrl.word.aluSrcB, SrcBImmShift, "decode ALU source B");
			end
			CtrlAdd, CtrlAnd, CtrlSub, CtrlXor:
			begin
				compareBit(ctrl.word.aluOutLoad, 1'b1, "ALUOut load in execute");
				compareSrcA(ctrl.word.aluSrcA, SrcARegA, "execute ALU source A");
				compareSrcB(ctrl.word.aluSrcB, SrcBRegB, "execute ALU source B");
			end
			CtrlRWrite:
			begin
				compareBit(ctrl.word.regWrite, 1'b1, "regWrite in R write");
				compareBit(ctrl.word.regDst, 1'b1, "rd destination in R write");
			end
			CtrlSwWrite, CtrlSwWait:
			begin
				compareBit(ctrl.word.memWrite, 1'b1, "memWrite in store");
				compareBit(ctrl.word.iorD, 1'b1, "data address in store");
			end
			CtrlLui:
				compareWbSel(ctrl.word.memToReg, WbUpperImm, "LUI write-back select");
			CtrlWriteBack:
				compareWbSel(ctrl.word.memToReg, WbMdr, "load write-back select");
			CtrlJump:
				comparePcSrc(ctrl.word.pcSource, PcJump, "jump PC source");
			default: ;
		endcase
	endtask

	// runs from one fetch falling edge to the next
	task automatic runRecord(input int idx);
		int base;
		int expCycles;
		int limit;
		int cycles;
		ctrlStateT expExec;
		aluOpT expAluOp;
		logic expPcLoad;
		ctrlStateT expWrState;
		ctrlStateT wrState;
		ctrlStateT prevState;
		base = 1 + idx * RecordWords;
		expCycles = int'(goldenMem[base+3]);
		expExec = ctrlStateT'(goldenMem[base+4]);
		expAluOp = aluOpT'(goldenMem[base+5][2:0]);
		expPcLoad = goldenMem[base+6][0];
		expWrState = ctrlStateT'(goldenMem[base+7]);
		limit = (expExec == CtrlBreak) ? expCycles : MaxSteps;
		cycles = 1;	// fetch cycle already seen
		wrState = CtrlReset;	// reset encoding means no write
		prevState = CtrlFetch;
		@(posedge Clk);
		#1;
		op = opcodeT'(goldenMem[base][5:0]);
		funct = functT'(goldenMem[base+1][5:0]);
		aluZero = goldenMem[base+2][0];
		while (cycles < limit)
		begin
			@(negedge Clk);
			if (ctrlState == CtrlFetch)
				break;
			cycles++;
			checkCycleRules();
			if (prevState == CtrlDecode)
			begin
				compareState(ctrlState, expExec, "state after decode");
				compareAluOp(ctrl.word.aluOp, expAluOp, "ALU op after decode");
				compareBit(ctrl.pcLoad, expPcLoad, "pcLoad after decode");
			end
			if (prevState == CtrlBreak)
				compareState(ctrlState, CtrlBreak, "state held after break");
			if (ctrl.word.regWrite)
				wrState = ctrlState;
			prevState = ctrlState;
		end
		if (expExec == CtrlBreak)
		begin
			compareState(ctrlState, CtrlBreak, "state at end of break record");
			applyReset();
		end
		else if (ctrlState != CtrlFetch)
		begin
			errorCount++;
			$display("record %0d never returned to fetch within %0d cycles", idx, MaxSteps);
			applyReset();
		end
		else
		begin
			compareCount(cycles, expCycles, "instruction length");
			compareState(wrState, expWrState, "register write state");
		end
	endtask

	initial
	begin
		rst = 1'b1;
		op = OpFunct;
		funct = FnNop;
		aluZero = 1'b0;
		loadGolden();
		if (recordCount == 0 || recordCount > MaxRecords)
		begin
			$display("golden file dv/controlGolden.txt is missing or has a bad record count");
			$display(">>> FAIL");
			$finish;
		end
		else
		begin
			applyReset();
			for (int r = 0; r < recordCount; r++)
				runRecord(r);
			$display("checks %0d, errors %0d", checkCount, errorCount);
			if (errorCount == 0)
				$display(">>> PASS");
			else
				$display(">>> FAIL");
			$finish;
		end
	end

	// twice the golden length plus every reset
	initial
	begin
		wait (fileLoaded);
		#(watchCycles * 2 * Period);
		$display("watchdog expired, the run did not finish in %0d cycles", watchCycles * 2);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/mipsControl_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsControlProperties
(
	input logic Clk,
	input logic rst,
	input mipsCtrlPkg::ctrlStateT ctrlState,
	input mipsCtrlPkg::ctrlOutT ctrl
);

	import mipsCtrlPkg::*;

	// one bus transfer per cycle
	noDoubleWrite: assert property (@(posedge Clk) disable iff (rst)
		!(ctrl.word.memWrite && ctrl.word.regWrite))
	else
		$error("memory write and register write active in the same cycle");

	pcLoadStates: assert property (@(posedge Clk) disable iff (rst)
		ctrl.pcLoad |-> ctrlState inside {CtrlFetchWait2, CtrlJump, CtrlBeq, CtrlBne})
	else
		$error("pcLoad active in state %s", ctrlState.name());

	resetState: assert property (@(posedge Clk)
		rst |=> ctrlState == CtrlReset)
	else
		$error("state did not go to reset after rst");

endmodule

bind mipsControl mipsControlProperties i_mipsControlProperties
(
	.Clk (Clk),
	.rst (rst),
	.ctrlState (ctrlState),
	.ctrl (ctrl)
);

`default_nettype wire

/* design/mipsControl.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsControl
(
	input logic Clk,
	input logic rst,
	input mipsCtrlPkg::opcodeT op,
	input mipsCtrlPkg::functT funct,
	input logic aluZero,
	output mipsCtrlPkg::ctrlStateT ctrlState,
	output mipsCtrlPkg::ctrlOutT ctrl
);

	import mipsCtrlPkg::*;

	instrClassT instrClass;

	instrDecode i_instrDecode
	(
		.op (op),
		.funct (funct),
		.instrClass (instrClass)
	);

	stateSequencer i_stateSequencer
	(
		.Clk (Clk),
		.rst (rst),
		.instrClass (instrClass),
		.state (ctrlState)
	);

	// strobes follow the registered state
	controlWordGen i_controlWordGen
	(
		.state (ctrlState),
		.aluZero (aluZero),
		.ctrl (ctrl)
	);

endmodule

`default_nettype wire

/* design/controlWordGen.sv */
`timescale 1ns/1ps
`default_nettype none

module controlWordGen
(
	input mipsCtrlPkg::ctrlStateT state,
	input logic aluZero,
	output mipsCtrlPkg::ctrlOutT ctrl
);

	import mipsCtrlPkg::*;

	ctrlWordT word;
	logic branchTaken;

	always_comb
	begin
		word = '0;	// everything idle, selects at index 0
		case (state)
			CtrlReset:
			begin
				word.regReset = 1'b1;	// clear all datapath registers
				word.aReset = 1'b1;
				word.bReset = 1'b1;
				word.mdrReset = 1'b1;
				word.aluOutReset = 1'b1;
				word.irReset = 1'b1;
			end

			CtrlFetch,
			CtrlFetchWait1:
			begin
				word.irWrite = 1'b1;	// hold the instruction read
				word.mdrLoad = 1'b1;
				word.aluSrcB = SrcBFour;
			end

			CtrlFetchWait2:
			begin
				word.irWrite = 1'b1;
				word.mdrLoad = 1'b1;
				word.aluOp = AluAdd;	// PC + 4
				word.aluSrcA = SrcAPc;
				word.aluSrcB = SrcBFour;
				word.pcSource = PcAlu;
				word.pcWrite = 1'b1;
			end

			CtrlDecode:
			begin
				word.aLoad = 1'b1;	// rs
				word.bLoad = 1'b1;	// rt
				word.aluOp = AluAdd;	// branch target ahead of time
				word.aluSrcA = SrcAPc;
				word.aluSrcB = SrcBImmShift;
				word.aluOutLoad = 1'b1;
			end

			CtrlAdd,
			CtrlAnd,
			CtrlSub,
			CtrlXor:
			begin
				word.aluSrcA = SrcARegA;
				word.aluSrcB = SrcBRegB;
				word.aluOutLoad = 1'b1;
				case (state)
					CtrlAnd: word.aluOp = AluAnd;
					CtrlSub: word.aluOp = AluSub;
					CtrlXor: word.aluOp = AluXor;
					default: word.aluOp = AluAdd;
				endcase
			end

			CtrlRWrite:
			begin
				word.regWrite = 1'b1;
				word.regDst = 1'b1;	// rd
				word.memToReg = WbAluOut;
			end

			CtrlBeq,
			CtrlBne:
			begin
				word.pcWriteCond = 1'b1;
				word.aluOp = AluSub;	// compare A and B
				word.aluSrcA = SrcARegA;
				word.aluSrcB = SrcBRegB;
				word.pcSource = PcAluOut;	// target from decode
			end

			CtrlJump:
			begin
				word.pcWrite = 1'b1;
				word.pcSource = PcJump;	// {pc[31:28], target, 00}
				word.aluOp = AluAdd;
				word.aluSrcB = SrcBImmShift;
				word.iorD = 1'b1;
				word.aluOutLoad = 1'b1;
			end

			CtrlLui:
			begin
				word.regWrite = 1'b1;	// rt
				word.memToReg = WbUpperImm;
			end

			CtrlLwAddr,
			CtrlSwAddr:
			begin
				word.aluOp = AluAdd;	// base + offset
				word.aluSrcA = SrcARegA;
				word.aluSrcB = SrcBImm;
				word.aluOutLoad = 1'b1;
			end

			CtrlLwRead,
			CtrlLwWait1,
			CtrlLwWait2:
			begin
				word.iorD = 1'b1;
				word.mdrLoad = 1'b1;
			end

			CtrlWriteBack:
			begin
				word.regWrite = 1'b1;
				word.memToReg = WbMdr;	// loaded word into rt
			end

			CtrlSwWrite,
			CtrlSwWait:
			begin
				word.memWrite = 1'b1;
				word.iorD = 1'b1;
			end

			default:
			begin
				word = '0;	// nop, break
			end
		endcase
	end

	// bne inverts the sense of the zero flag
	assign branchTaken = (state == CtrlBne) ? ~aluZero : aluZero;

	assign ctrl.word = word;
	assign ctrl.pcLoad = word.pcWrite | (word.pcWriteCond & branchTaken);

endmodule

`default_nettype wire

/* design/stateSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module stateSequencer
(
	input logic Clk,
	input logic rst,
	input mipsCtrlPkg::instrClassT instrClass,	// sampled in decode only
	output mipsCtrlPkg::ctrlStateT state
);

	import mipsCtrlPkg::*;

	ctrlStateT nextState;

	always_ff @(posedge Clk)
	begin
		if (rst)
			state <= CtrlReset;
		else
			state <= nextState;
	end

	// dispatch on the decoded class
	function automatic ctrlStateT decodeTarget(input instrClassT cls);
		ctrlStateT tgt;
		case (cls)
			InstrAdd: tgt = CtrlAdd;
			InstrAnd: tgt = CtrlAnd;
			InstrSub: tgt = CtrlSub;
			InstrXor: tgt = CtrlXor;
			InstrNop: tgt = CtrlNop;
			InstrBreak: tgt = CtrlBreak;
			InstrBeq: tgt = CtrlBeq;
			InstrBne: tgt = CtrlBne;
			InstrLw: tgt = CtrlLwAddr;
			InstrSw: tgt = CtrlSwAddr;
			InstrLui: tgt = CtrlLui;
			InstrJ: tgt = CtrlJump;
			default: tgt = CtrlNop;	// illegal idles one cycle, then refetch
		endcase
		return tgt;
	endfunction

	always_comb
	begin
		case (state)
			CtrlReset: nextState = CtrlFetch;
			CtrlFetch: nextState = CtrlFetchWait1;
			CtrlFetchWait1: nextState = CtrlFetchWait2;
			CtrlFetchWait2: nextState = CtrlDecode;
			CtrlDecode:
			begin
				nextState = decodeTarget(instrClass);
			end

			CtrlAdd,
			CtrlAnd,
			CtrlSub,
			CtrlXor: nextState = CtrlRWrite;	// result written next cycle
			CtrlRWrite: nextState = CtrlFetch;

			CtrlBreak: nextState = CtrlBreak;	// parked until reset

			CtrlNop,
			CtrlBeq,
			CtrlBne,
			CtrlJump,
			CtrlLui: nextState = CtrlFetch;

			// load chain, two extra memory delays
			CtrlLwAddr: nextState = CtrlLwRead;
			CtrlLwRead: nextState = CtrlLwWait1;
			CtrlLwWait1: nextState = CtrlLwWait2;
			CtrlLwWait2: nextState = CtrlWriteBack;
			CtrlWriteBack: nextState = CtrlFetch;

			CtrlSwAddr: nextState = CtrlSwWrite;
			CtrlSwWrite: nextState = CtrlSwWait;
			CtrlSwWait: nextState = CtrlFetch;

			default:
			begin
				nextState = CtrlFetch;
			end
		endcase
	end

endmodule

`default_nettype wire

/* design/instrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecode
(
	input mipsCtrlPkg::opcodeT op,
	input mipsCtrlPkg::functT funct,	// only meaningful for R-type
	output mipsCtrlPkg::instrClassT instrClass
);

	import mipsCtrlPkg::*;

	instrClassT rClass;

	// R-type group selected by the function field
	always_comb
	begin
		case (funct)
			FnAdd: rClass = InstrAdd;
			FnAnd: rClass = InstrAnd;
			FnSub: rClass = InstrSub;
			FnXor: rClass = InstrXor;
			FnNop: rClass = InstrNop;
			FnBreak: rClass = InstrBreak;
			default: rClass = InstrIllegal;	// unknown funct
		endcase
	end

	always_comb
	begin
		case (op)
			OpFunct:
			begin
				instrClass = rClass;
			end
			OpBeq: instrClass = InstrBeq;
			OpBne: instrClass = InstrBne;
			OpLw: instrClass = InstrLw;
			OpSw: instrClass = InstrSw;
			OpLui: instrClass = InstrLui;
			OpJ: instrClass = InstrJ;
			default:
			begin
				instrClass = InstrIllegal;	// unknown opcode
			end
		endcase
	end

endmodule

`default_nettype wire

/* design/mipsCtrlPkg.sv */
`default_nettype none

package mipsCtrlPkg;

	localparam int OpWidth = 6;
	localparam int FunctWidth = 6;

	typedef enum logic [OpWidth-1:0]
	{
		OpFunct = 6'h00,	// R-type, look at funct
		OpJ = 6'h02,
		OpBeq = 6'h04,
		OpBne = 6'h05,
		OpLui = 6'h0f,
		OpLw = 6'h23,
		OpSw = 6'h2b
	} opcodeT;

	typedef enum logic [FunctWidth-1:0]
	{
		FnNop = 6'h00,
		FnBreak = 6'h0d,
		FnAdd = 6'h20,
		FnSub = 6'h22,
		FnAnd = 6'h24,
		FnXor = 6'h26
	} functT;

	typedef enum logic [3:0]
	{
		InstrAdd, InstrAnd, InstrSub, InstrXor, InstrNop, InstrBreak, InstrBeq,
		InstrBne, InstrLw, InstrSw, InstrLui, InstrJ, InstrIllegal
	} instrClassT;

	typedef enum logic [7:0]
	{
		CtrlReset, CtrlFetch, CtrlFetchWait1, CtrlFetchWait2, CtrlDecode,
		CtrlAdd, CtrlAnd, CtrlSub, CtrlXor, CtrlRWrite, CtrlNop, CtrlBreak,
		CtrlBeq, CtrlBne, CtrlJump, CtrlLui,
		CtrlLwAddr, CtrlLwRead, CtrlLwWait1, CtrlLwWait2, CtrlWriteBack,
		CtrlSwAddr, CtrlSwWrite, CtrlSwWait
	} ctrlStateT;

	typedef enum logic [2:0]
	{
		AluNone = 3'd0,
		AluAdd = 3'd1,
		AluSub = 3'd2,
		AluAnd = 3'd3,
		AluXor = 3'd6
	} aluOpT;

	typedef enum logic {SrcAPc, SrcARegA} aluSrcAT;
	typedef enum logic [1:0] {SrcBRegB, SrcBFour, SrcBImm, SrcBImmShift} aluSrcBT;
	typedef enum logic [1:0] {WbAluOut, WbMdr, WbUpperImm} memToRegT;
	typedef enum logic [1:0] {PcAlu, PcAluOut, PcJump} pcSourceT;

	typedef struct packed
	{
		logic memWrite;		// memory write, read otherwise
		logic iorD;			// 1 selects data address
		logic irWrite;
		logic mdrLoad;
		logic regWrite;
		logic regDst;		// 1 selects rd, 0 rt
		memToRegT memToReg;
		logic regReset;
		aluOpT aluOp;
		aluSrcAT aluSrcA;
		aluSrcBT aluSrcB;
		pcSourceT pcSource;
		logic pcWrite;		// unconditional
		logic pcWriteCond;	// branch, qualified by zero flag
		logic aLoad;
		logic aReset;
		logic bLoad;
		logic bReset;
		logic aluOutLoad;
		logic aluOutReset;
		logic mdrReset;
		logic irReset;
	} ctrlWordT;

	typedef struct packed
	{
		ctrlWordT word;
		logic pcLoad;		// final PC enable
	} ctrlOutT;

endpackage

`default_nettype wire
